// File: include/rvc_defs.svh
`ifndef RVC_DEFS_SVH
`define RVC_DEFS_SVH

// full base instruction and compressed parcel
`define RVC_ILEN 32
`define RVC_CLEN 16

// register numbers
`define RVC_REG_W 5
`define RVC_REG_SP 2
`define RVC_REG_RA 1

// 3-bit register fields reach x8..x15
`define RVC_CREG_BASE 8

`endif

// File: verilog/rvc_isa_pkg.sv
package rvc_isa_pkg;

	// major opcode, insn[6:2]
	typedef enum logic [4:0] {
		opc_load = 5'b00000,
		opc_op_imm = 5'b00100,
		opc_op_imm_32 = 5'b00110,
		opc_store = 5'b01000,
		opc_op = 5'b01100,
		opc_lui = 5'b01101,
		opc_op_32 = 5'b01110,
		opc_branch = 5'b11000,
		opc_jalr = 5'b11001,
		opc_jal = 5'b11011,
		opc_system = 5'b11100
	} opcode_e;

	// bit layouts of the base instruction
	typedef enum logic [2:0] {
		fmt_r,
		fmt_i,
		fmt_s,
		fmt_b,
		fmt_u,
		fmt_j,
		fmt_pass
	} format_e;

endpackage

// File: verilog/rvc_kind_pkg.sv
package rvc_kind_pkg;

	// one entry per compressed operation group
	typedef enum logic [4:0] {
		kind_uncompressed,
		kind_illegal,
		kind_addi4spn,
		kind_load,
		kind_store,
		kind_addi_li,
		kind_addiw_jal,
		kind_addi16sp,
		kind_lui,
		kind_shift_right,
		kind_andi,
		kind_arith,
		kind_arith_w,
		kind_j,
		kind_branch,
		kind_slli,
		kind_load_sp,
		kind_store_sp,
		kind_ebreak,
		kind_jr_jalr,
		kind_mv_add
	} kind_e;

endpackage

// File: verilog/rvc_classify.sv
`timescale 1ns/10ps
`include "rvc_defs.svh"

module rvc_classify #(
	parameter bit rv64 = 1'b1
) (
	input logic clk_i,
	input logic reset_i,
	input logic in_valid_i,
	output logic in_ready_o,
	input logic [`RVC_ILEN-1:0] insn_i,
	output logic out_valid_o,
	input logic out_ready_i,
	output rvc_kind_pkg::kind_e kind_o,
	output logic [`RVC_ILEN-1:0] word_o,
	output logic compressed_o
);
	logic [`RVC_CLEN-1:0] parcel;
	rvc_kind_pkg::kind_e kind_d;

	assign parcel = insn_i[`RVC_CLEN-1:0];
	assign in_ready_o = ~out_valid_o | out_ready_i;

	// first match wins
	always_comb begin
		priority casez (parcel)
			16'b0000_0000_0000_0000: kind_d = rvc_kind_pkg::kind_illegal;
			16'b000_???????????_00: kind_d = rvc_kind_pkg::kind_addi4spn;
			16'b010_???????????_00: kind_d = rvc_kind_pkg::kind_load;
			16'b011_???????????_00:
				kind_d = rv64 ? rvc_kind_pkg::kind_load : rvc_kind_pkg::kind_illegal;
			16'b110_???????????_00: kind_d = rvc_kind_pkg::kind_store;
			16'b111_???????????_00:
				kind_d = rv64 ? rvc_kind_pkg::kind_store : rvc_kind_pkg::kind_illegal;
			// fld, fsd and the Zcb group also land here
			16'b???_???????????_00: kind_d = rvc_kind_pkg::kind_illegal;

			16'b0?0_???????????_01: kind_d = rvc_kind_pkg::kind_addi_li;
			16'b001_???????????_01: kind_d = rvc_kind_pkg::kind_addiw_jal;
			16'b011_?_00010_?????_01: kind_d = rvc_kind_pkg::kind_addi16sp;
			16'b011_???????????_01: kind_d = rvc_kind_pkg::kind_lui;
			16'b100_?_0?_???_?????_01:
				kind_d = (!rv64 && parcel[12]) ? rvc_kind_pkg::kind_illegal
					: rvc_kind_pkg::kind_shift_right;
			16'b100_?_10_???_?????_01: kind_d = rvc_kind_pkg::kind_andi;
			16'b100_0_11_???_??_???_01: kind_d = rvc_kind_pkg::kind_arith;
			16'b100_1_11_???_0?_???_01:
				kind_d = rv64 ? rvc_kind_pkg::kind_arith_w : rvc_kind_pkg::kind_illegal;
			16'b100_1_11_???_1?_???_01: kind_d = rvc_kind_pkg::kind_illegal;
			16'b101_???????????_01: kind_d = rvc_kind_pkg::kind_j;
			16'b11?_???????????_01: kind_d = rvc_kind_pkg::kind_branch;

			16'b000_???????????_10:
				kind_d = (!rv64 && parcel[12]) ? rvc_kind_pkg::kind_illegal
					: rvc_kind_pkg::kind_slli;
			16'b010_???????????_10: kind_d = rvc_kind_pkg::kind_load_sp;
			16'b011_???????????_10:
				kind_d = rv64 ? rvc_kind_pkg::kind_load_sp : rvc_kind_pkg::kind_illegal;
			16'b100_1_00000_00000_10: kind_d = rvc_kind_pkg::kind_ebreak;
			16'b100_?_00000_?????_10: kind_d = rvc_kind_pkg::kind_illegal;
			16'b100_?_?????_00000_10: kind_d = rvc_kind_pkg::kind_jr_jalr;
			16'b100_?_?????_?????_10: kind_d = rvc_kind_pkg::kind_mv_add;
			16'b110_???????????_10: kind_d = rvc_kind_pkg::kind_store_sp;
			16'b111_???????????_10:
				kind_d = rv64 ? rvc_kind_pkg::kind_store_sp : rvc_kind_pkg::kind_illegal;
			// fldsp and fsdsp
			16'b???_???????????_10: kind_d = rvc_kind_pkg::kind_illegal;

			16'b??????????????_11: kind_d = rvc_kind_pkg::kind_uncompressed;
			default: kind_d = rvc_kind_pkg::kind_illegal;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			out_valid_o <= 1'b0;
		end else if (in_ready_o) begin
			out_valid_o <= in_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (in_valid_i && in_ready_o) begin
			kind_o <= kind_d;
			word_o <= insn_i;
			compressed_o <= ~&parcel[1:0];
		end
	end

endmodule

// File: verilog/rvc_operand_gen.sv
`timescale 1ns/10ps
`include "rvc_defs.svh"

module rvc_operand_gen #(
	parameter bit rv64 = 1'b1
) (
	input logic clk_i,
	input logic reset_i,
	input logic in_valid_i,
	output logic in_ready_o,
	input rvc_kind_pkg::kind_e kind_i,
	input logic [`RVC_ILEN-1:0] word_i,
	input logic compressed_i,
	output logic out_valid_o,
	input logic out_ready_i,
	output rvc_isa_pkg::opcode_e opcode_o,
	output rvc_isa_pkg::format_e format_o,
	output logic [`RVC_REG_W-1:0] rd_o,
	output logic [`RVC_REG_W-1:0] rs1_o,
	output logic [`RVC_REG_W-1:0] rs2_o,
	output logic [2:0] funct3_o,
	output logic [6:0] funct7_o,
	output logic [`RVC_ILEN-1:0] imm_o,
	output logic [`RVC_ILEN-1:0] word_o,
	output logic compressed_o,
	output logic illegal_o
);
	logic [`RVC_CLEN-1:0] c;
	logic [`RVC_REG_W-1:0] rdp;
	logic [`RVC_REG_W-1:0] rs1p;
	logic [`RVC_ILEN-1:0] imm6_s;
	logic [`RVC_ILEN-1:0] imm_cj;
	logic [`RVC_ILEN-1:0] imm_cl;
	logic [`RVC_ILEN-1:0] imm_lsp;
	logic [`RVC_ILEN-1:0] imm_ssp;
	rvc_isa_pkg::opcode_e opcode_d;
	rvc_isa_pkg::format_e format_d;
	logic [`RVC_REG_W-1:0] rd_d;
	logic [`RVC_REG_W-1:0] rs1_d;
	logic [`RVC_REG_W-1:0] rs2_d;
	logic [2:0] funct3_d;
	logic [6:0] funct7_d;
	logic [`RVC_ILEN-1:0] imm_d;
	logic illegal_d;

	assign c = word_i[`RVC_CLEN-1:0];
	assign in_ready_o = ~out_valid_o | out_ready_i;

	// compact register fields
	assign rdp = `RVC_REG_W'(`RVC_CREG_BASE + c[4:2]);
	assign rs1p = `RVC_REG_W'(`RVC_CREG_BASE + c[9:7]);

	assign imm6_s = unsigned'(`RVC_ILEN'(signed'({c[12], c[6:2]})));
	assign imm_cj = unsigned'(`RVC_ILEN'(signed'({c[12], c[8], c[10:9], c[6], c[7],
		c[2], c[11], c[5:3], 1'b0})));
	// bit 13 selects the double-word scaling
	assign imm_cl = `RVC_ILEN'({c[13] & c[6], c[5], c[12:10], ~c[13] & c[6], 2'b00});
	assign imm_lsp = `RVC_ILEN'({c[13] & c[4], c[3:2], c[12], c[6:5], ~c[13] & c[4], 2'b00});
	assign imm_ssp = `RVC_ILEN'({c[13] & c[9], c[8:7], c[12:10], ~c[13] & c[9], 2'b00});

	always_comb begin
		// most kinds are I-type on the full rd field
		opcode_d = rvc_isa_pkg::opc_op_imm;
		format_d = rvc_isa_pkg::fmt_i;
		rd_d = c[11:7];
		rs1_d = c[11:7];
		rs2_d = c[6:2];
		funct3_d = 3'b000;
		funct7_d = 7'b0000000;
		imm_d = imm6_s;
		illegal_d = 1'b0;
		case (kind_i)
			rvc_kind_pkg::kind_uncompressed: format_d = rvc_isa_pkg::fmt_pass;
			rvc_kind_pkg::kind_addi4spn: begin
				rd_d = rdp;
				rs1_d = `RVC_REG_SP;
				imm_d = `RVC_ILEN'({c[10:7], c[12:11], c[5], c[6], 2'b00});
			end
			rvc_kind_pkg::kind_load: begin
				opcode_d = rvc_isa_pkg::opc_load;
				rd_d = rdp;
				rs1_d = rs1p;
				funct3_d = {2'b01, c[13]};
				imm_d = imm_cl;
			end
			rvc_kind_pkg::kind_store: begin
				opcode_d = rvc_isa_pkg::opc_store;
				format_d = rvc_isa_pkg::fmt_s;
				rs1_d = rs1p;
				rs2_d = rdp;
				funct3_d = {2'b01, c[13]};
				imm_d = imm_cl;
			end
			rvc_kind_pkg::kind_addi_li: begin
				if (c[14]) begin
					rs1_d = '0;
				end
			end
			rvc_kind_pkg::kind_addiw_jal: begin
				if (rv64) begin
					opcode_d = rvc_isa_pkg::opc_op_imm_32;
				end else begin
					opcode_d = rvc_isa_pkg::opc_jal;
					format_d = rvc_isa_pkg::fmt_j;
					rd_d = `RVC_REG_RA;
					imm_d = imm_cj;
				end
			end
			rvc_kind_pkg::kind_addi16sp: begin
				rd_d = `RVC_REG_SP;
				rs1_d = `RVC_REG_SP;
				imm_d = unsigned'(`RVC_ILEN'(signed'({c[12], c[4:3], c[5], c[2], c[6], 4'b0000})));
			end
			rvc_kind_pkg::kind_lui: begin
				opcode_d = rvc_isa_pkg::opc_lui;
				format_d = rvc_isa_pkg::fmt_u;
				imm_d = unsigned'(`RVC_ILEN'(signed'({c[12], c[6:2], 12'h000})));
			end
			rvc_kind_pkg::kind_shift_right: begin
				rd_d = rs1p;
				rs1_d = rs1p;
				funct3_d = 3'b101;
				// c[10] becomes the srai bit
				imm_d = `RVC_ILEN'({c[10], 4'b0000, c[12], c[6:2]});
			end
			rvc_kind_pkg::kind_andi: begin
				rd_d = rs1p;
				rs1_d = rs1p;
				funct3_d = 3'b111;
			end
			rvc_kind_pkg::kind_arith: begin
				opcode_d = rvc_isa_pkg::opc_op;
				format_d = rvc_isa_pkg::fmt_r;
				rd_d = rs1p;
				rs1_d = rs1p;
				rs2_d = rdp;
				funct3_d = {|c[6:5], c[6], &c[6:5]};
				funct7_d = {1'b0, ~|c[6:5], 5'b00000};
			end
			rvc_kind_pkg::kind_arith_w: begin
				opcode_d = rvc_isa_pkg::opc_op_32;
				format_d = rvc_isa_pkg::fmt_r;
				rd_d = rs1p;
				rs1_d = rs1p;
				rs2_d = rdp;
				funct7_d = {1'b0, ~c[5], 5'b00000};
			end
			rvc_kind_pkg::kind_j: begin
				opcode_d = rvc_isa_pkg::opc_jal;
				format_d = rvc_isa_pkg::fmt_j;
				rd_d = '0;
				imm_d = imm_cj;
			end
			rvc_kind_pkg::kind_branch: begin
				opcode_d = rvc_isa_pkg::opc_branch;
				format_d = rvc_isa_pkg::fmt_b;
				rs1_d = rs1p;
				rs2_d = '0;
				funct3_d = {2'b00, c[13]};
				imm_d = unsigned'(`RVC_ILEN'(signed'({c[12], c[6:5], c[2], c[11:10], c[4:3],
					1'b0})));
			end
			rvc_kind_pkg::kind_slli: begin
				funct3_d = 3'b001;
				imm_d = `RVC_ILEN'({c[12], c[6:2]});
			end
			rvc_kind_pkg::kind_load_sp: begin
				opcode_d = rvc_isa_pkg::opc_load;
				rs1_d = `RVC_REG_SP;
				funct3_d = {2'b01, c[13]};
				imm_d = imm_lsp;
			end
			rvc_kind_pkg::kind_store_sp: begin
				opcode_d = rvc_isa_pkg::opc_store;
				format_d = rvc_isa_pkg::fmt_s;
				rs1_d = `RVC_REG_SP;
				funct3_d = {2'b01, c[13]};
				imm_d = imm_ssp;
			end
			rvc_kind_pkg::kind_ebreak: begin
				opcode_d = rvc_isa_pkg::opc_system;
				rd_d = '0;
				rs1_d = '0;
				imm_d = `RVC_ILEN'(1);
			end
			rvc_kind_pkg::kind_jr_jalr: begin
				opcode_d = rvc_isa_pkg::opc_jalr;
				rd_d = c[12] ? `RVC_REG_W'(`RVC_REG_RA) : '0;
				imm_d = '0;
			end
			rvc_kind_pkg::kind_mv_add: begin
				opcode_d = rvc_isa_pkg::opc_op;
				format_d = rvc_isa_pkg::fmt_r;
				// mv reads x0 as rs1
				if (!c[12]) begin
					rs1_d = '0;
				end
			end
			default: begin
				format_d = rvc_isa_pkg::fmt_pass;
				illegal_d = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			out_valid_o <= 1'b0;
		end else if (in_ready_o) begin
			out_valid_o <= in_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (in_valid_i && in_ready_o) begin
			opcode_o <= opcode_d;
			format_o <= format_d;
			rd_o <= rd_d;
			rs1_o <= rs1_d;
			rs2_o <= rs2_d;
			funct3_o <= funct3_d;
			funct7_o <= funct7_d;
			imm_o <= imm_d;
			word_o <= word_i;
			compressed_o <= compressed_i;
			illegal_o <= illegal_d;
		end
	end

endmodule

// File: verilog/rvc_encode.sv
`timescale 1ns/10ps
`include "rvc_defs.svh"

module rvc_encode (
	input logic clk_i,
	input logic reset_i,
	input logic in_valid_i,
	output logic in_ready_o,
	input rvc_isa_pkg::opcode_e opcode_i,
	input rvc_isa_pkg::format_e format_i,
	input logic [`RVC_REG_W-1:0] rd_i,
	input logic [`RVC_REG_W-1:0] rs1_i,
	input logic [`RVC_REG_W-1:0] rs2_i,
	input logic [2:0] funct3_i,
	input logic [6:0] funct7_i,
	input logic [`RVC_ILEN-1:0] imm_i,
	input logic [`RVC_ILEN-1:0] word_i,
	input logic compressed_i,
	input logic illegal_i,
	output logic out_valid_o,
	input logic out_ready_i,
	output logic [`RVC_ILEN-1:0] insn_o,
	output logic compressed_o,
	output logic illegal_o
);
	logic [`RVC_ILEN-1:0] insn_d;

	assign in_ready_o = ~out_valid_o | out_ready_i;

	always_comb begin
		case (format_i)
			rvc_isa_pkg::fmt_r:
				insn_d = {funct7_i, rs2_i, rs1_i, funct3_i, rd_i, opcode_i, 2'b11};
			rvc_isa_pkg::fmt_i:
				insn_d = {imm_i[11:0], rs1_i, funct3_i, rd_i, opcode_i, 2'b11};
			rvc_isa_pkg::fmt_s:
				insn_d = {imm_i[11:5], rs2_i, rs1_i, funct3_i, imm_i[4:0], opcode_i, 2'b11};
			// branch and jump offsets are scrambled, bit 0 implied
			rvc_isa_pkg::fmt_b:
				insn_d = {imm_i[12], imm_i[10:5], rs2_i, rs1_i, funct3_i, imm_i[4:1], imm_i[11],
					opcode_i, 2'b11};
			rvc_isa_pkg::fmt_u:
				insn_d = {imm_i[31:12], rd_i, opcode_i, 2'b11};
			rvc_isa_pkg::fmt_j:
				insn_d = {imm_i[20], imm_i[10:1], imm_i[11], imm_i[19:12], rd_i, opcode_i, 2'b11};
			default:
				insn_d = word_i;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			out_valid_o <= 1'b0;
		end else if (in_ready_o) begin
			out_valid_o <= in_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (in_valid_i && in_ready_o) begin
			insn_o <= insn_d;
			compressed_o <= compressed_i;
			illegal_o <= illegal_i;
		end
	end

endmodule

// File: verilog/rvc_expander.sv
`timescale 1ns/10ps
`include "rvc_defs.svh"

module rvc_expander #(
	parameter bit rv64 = 1'b1
) (
	input logic clk_i,
	input logic reset_i,
	input logic in_valid_i,
	output logic in_ready_o,
	input logic [`RVC_ILEN-1:0] insn_i,
	output logic out_valid_o,
	input logic out_ready_i,
	output logic [`RVC_ILEN-1:0] insn_o,
	output logic compressed_o,
	output logic illegal_o
);
	// classify to operand stage
	logic cls_valid;
	logic cls_ready;
	rvc_kind_pkg::kind_e cls_kind;
	logic [`RVC_ILEN-1:0] cls_word;
	logic cls_compressed;

	// operand stage to encoder
	logic opg_valid;
	logic opg_ready;
	rvc_isa_pkg::opcode_e opg_opcode;
	rvc_isa_pkg::format_e opg_format;
	logic [`RVC_REG_W-1:0] opg_rd;
	logic [`RVC_REG_W-1:0] opg_rs1;
	logic [`RVC_REG_W-1:0] opg_rs2;
	logic [2:0] opg_funct3;
	logic [6:0] opg_funct7;
	logic [`RVC_ILEN-1:0] opg_imm;
	logic [`RVC_ILEN-1:0] opg_word;
	logic opg_compressed;
	logic opg_illegal;

	rvc_classify #(
		.rv64(rv64)
	) u_classify (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.in_valid_i(in_valid_i),
		.in_ready_o(in_ready_o),
		.insn_i(insn_i),
		.out_valid_o(cls_valid),
		.out_ready_i(cls_ready),
		.kind_o(cls_kind),
		.word_o(cls_word),
		.compressed_o(cls_compressed)
	);

	rvc_operand_gen #(
		.rv64(rv64)
	) u_operand_gen (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.in_valid_i(cls_valid),
		.in_ready_o(cls_ready),
		.kind_i(cls_kind),
		.word_i(cls_word),
		.compressed_i(cls_compressed),
		.out_valid_o(opg_valid),
		.out_ready_i(opg_ready),
		.opcode_o(opg_opcode),
		.format_o(opg_format),
		.rd_o(opg_rd),
		.rs1_o(opg_rs1),
		.rs2_o(opg_rs2),
		.funct3_o(opg_funct3),
		.funct7_o(opg_funct7),
		.imm_o(opg_imm),
		.word_o(opg_word),
		.compressed_o(opg_compressed),
		.illegal_o(opg_illegal)
	);

	rvc_encode u_encode (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.in_valid_i(opg_valid),
		.in_ready_o(opg_ready),
		.opcode_i(opg_opcode),
		.format_i(opg_format),
		.rd_i(opg_rd),
		.rs1_i(opg_rs1),
		.rs2_i(opg_rs2),
		.funct3_i(opg_funct3),
		.funct7_i(opg_funct7),
		.imm_i(opg_imm),
		.word_i(opg_word),
		.compressed_i(opg_compressed),
		.illegal_i(opg_illegal),
		.out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i),
		.insn_o(insn_o),
		.compressed_o(compressed_o),
		.illegal_o(illegal_o)
	);

endmodule

// File: test/rvc_expander_chk.sv
`timescale 1ns/10ps
`include "rvc_defs.svh"

module rvc_expander_chk (
	input logic clk_i,
	input logic reset_i,
	input logic in_ready_o,
	input logic out_valid_o,
	input logic out_ready_i,
	input logic [`RVC_ILEN-1:0] insn_o,
	input logic compressed_o,
	input logic illegal_o
);
	// pipeline empties on reset
	a_reset_empty: assert property (@(posedge clk_i) reset_i |=> !out_valid_o)
		else $error("out_valid_o high after reset");

	// output held while stalled
	a_hold: assert property (@(posedge clk_i) disable iff (reset_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(insn_o))
		else $error("output dropped or changed under back-pressure");

	a_illegal_compressed: assert property (@(posedge clk_i) disable iff (reset_i)
		out_valid_o && illegal_o |-> compressed_o)
		else $error("illegal_o without compressed_o");

	// ready ripples back through every stage
	a_ready_path: assert property (@(posedge clk_i) disable iff (reset_i)
		out_ready_i |-> in_ready_o)
		else $error("in_ready_o low while out_ready_i high");

endmodule

bind rvc_expander rvc_expander_chk u_chk (.*);

// File: test/rvc_expander_tb.sv
`timescale 1ns/10ps
`include "rvc_defs.svh"

module rvc_expander_tb;
	logic clk_i = 1'b0;
	logic reset_i;
	logic in_valid_i;
	logic in_ready_o;
	logic [`RVC_ILEN-1:0] insn_i;
	logic out_valid_o;
	logic out_ready_i;
	logic [`RVC_ILEN-1:0] insn_o;
	logic compressed_o;
	logic illegal_o;

	// stimulus table
	string names[64];
	logic [`RVC_ILEN-1:0] words[64];
	bit exp_ill[64];
	bit exp_cmp[64];
	logic [`RVC_ILEN-1:0] exp_word[64];
	int n_rows = 0;

	int exp_q[$];
	int errors = 0;
	bit hung = 1'b0;
	int phase = 0;
	int cyc = 0;
	int out_count = 0;
	int first_accept = -1;
	int last_out = -1;
	integer seed = 14502;
	integer rnd;

	rvc_expander #(
		.rv64(1'b1)
	) u_dut (
		.clk_i(clk_i),
		.reset_i(reset_i),
		.in_valid_i(in_valid_i),
		.in_ready_o(in_ready_o),
		.insn_i(insn_i),
		.out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i),
		.insn_o(insn_o),
		.compressed_o(compressed_o),
		.illegal_o(illegal_o)
	);

	always #10 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cyc <= cyc + 1;
		if (phase == 1) begin
			rnd = $random(seed);
			out_ready_i <= rnd[0];
		end else begin
			out_ready_i <= 1'b1;
		end
	end

	task automatic add_row(input string name, input logic [31:0] word, input bit ill,
		input bit cmp, input logic [31:0] exp);
		names[n_rows] = name;
		words[n_rows] = word;
		exp_ill[n_rows] = ill;
		exp_cmp[n_rows] = cmp;
		exp_word[n_rows] = exp;
		n_rows++;
	endtask

	task automatic fill_table();
		add_row("addi4spn", 32'h0040, 0, 1, 32'h00410413);
		add_row("lw", 32'h4144, 0, 1, 32'h00452483);
		add_row("ld", 32'h6504, 0, 1, 32'h00853483);
		add_row("sw", 32'hC144, 0, 1, 32'h00952223);
		add_row("sd", 32'hE504, 0, 1, 32'h00953423);
		add_row("addi", 32'h0085, 0, 1, 32'h00108093);
		add_row("li", 32'h52FD, 0, 1, 32'hFFF00293);
		add_row("addiw", 32'h2505, 0, 1, 32'h0015051B);
		add_row("addi16sp", 32'h6141, 0, 1, 32'h01010113);
		add_row("lui", 32'h6505, 0, 1, 32'h00001537);
		add_row("srli", 32'h8005, 0, 1, 32'h00145413);
		add_row("srai", 32'h8405, 0, 1, 32'h40145413);
		add_row("andi", 32'h880D, 0, 1, 32'h00347413);
		add_row("sub", 32'h8C05, 0, 1, 32'h40940433);
		add_row("xor", 32'h8C25, 0, 1, 32'h00944433);
		add_row("or", 32'h8C45, 0, 1, 32'h00946433);
		add_row("and", 32'h8C65, 0, 1, 32'h00947433);
		add_row("subw", 32'h9C05, 0, 1, 32'h4094043B);
		add_row("addw", 32'h9C25, 0, 1, 32'h0094043B);
		add_row("j", 32'hA009, 0, 1, 32'h0020006F);
		add_row("beqz", 32'hC001, 0, 1, 32'h00040063);
		add_row("bnez", 32'hE011, 0, 1, 32'h00041263);
		add_row("slli", 32'h0086, 0, 1, 32'h00109093);
		add_row("lwsp", 32'h4092, 0, 1, 32'h00412083);
		add_row("ldsp", 32'h60A2, 0, 1, 32'h00813083);
		add_row("swsp", 32'hC206, 0, 1, 32'h00112223);
		add_row("sdsp", 32'hE406, 0, 1, 32'h00113423);
		add_row("jr", 32'h8082, 0, 1, 32'h00008067);
		add_row("jalr", 32'h9282, 0, 1, 32'h000280E7);
		add_row("mv", 32'h829A, 0, 1, 32'h006002B3);
		add_row("add", 32'h929A, 0, 1, 32'h006282B3);
		add_row("ebreak", 32'h9002, 0, 1, 32'h00100073);
		// word not compared when illegal
		add_row("zero_parcel", 32'h0000, 1, 1, 32'h0);
		add_row("reserved_arith", 32'h9C45, 1, 1, 32'h0);
		add_row("fld", 32'h2004, 1, 1, 32'h0);
		add_row("fsd", 32'hA004, 1, 1, 32'h0);
		add_row("lbu", 32'h8004, 1, 1, 32'h0);
		add_row("uncompressed", 32'h00A00513, 0, 0, 32'h00A00513);
	endtask

	// ready is stable between the falling edge and the next rising edge
	task automatic drive_table();
		int i;
		int wait_cnt;
		for (i = 0; i < n_rows && !hung; i++) begin
			@(posedge clk_i);
			in_valid_i <= 1'b1;
			insn_i <= words[i];
			wait_cnt = 0;
			@(negedge clk_i);
			while (!in_ready_o && !hung) begin
				wait_cnt++;
				if (wait_cnt > 50) begin
					$display("timeout: input handshake for %s never completed", names[i]);
					hung = 1'b1;
					errors++;
				end else begin
					@(negedge clk_i);
				end
			end
			if (!hung) begin
				exp_q.push_back(i);
				if (phase == 2 && first_accept < 0) begin
					first_accept = cyc + 1;
				end
			end
		end
		@(posedge clk_i);
		in_valid_i <= 1'b0;
	endtask

	task automatic wait_outputs(input int target);
		int wait_cnt;
		wait_cnt = 0;
		while (out_count < target && !hung) begin
			wait_cnt++;
			if (wait_cnt > 400) begin
				$display("timeout: only %0d of %0d outputs arrived", out_count, target);
				hung = 1'b1;
				errors++;
			end else begin
				@(posedge clk_i);
			end
		end
	endtask

	task automatic check_output();
		int idx;
		if (exp_q.size() == 0) begin
			$display("unexpected output with no pending input, word %h", insn_o);
			errors++;
		end else begin
			idx = exp_q.pop_front();
			if (compressed_o !== exp_cmp[idx]) begin
				$display("[ERROR] %s compressed: expected %0b actual %0b", names[idx],
					exp_cmp[idx], compressed_o);
				errors++;
			end
			if (illegal_o !== exp_ill[idx]) begin
				$display("[ERROR] %s illegal: expected %0b actual %0b", names[idx],
					exp_ill[idx], illegal_o);
				errors++;
			end
			if (!exp_ill[idx] && insn_o !== exp_word[idx]) begin
				$display("[ERROR] %s word: expected %h actual %h", names[idx],
					exp_word[idx], insn_o);
				errors++;
			end
		end
		out_count++;
		// fixed latency and one result per cycle in the free-flowing pass
		// output transfer lands on the next rising edge
		if (phase == 2) begin
			if (last_out < 0 && cyc + 1 - first_accept != 3) begin
				$display("[ERROR] latency: expected 3 actual %0d", cyc + 1 - first_accept);
				errors++;
			end
			if (last_out >= 0 && cyc != last_out + 1) begin
				$display("[ERROR] stream gap: expected %0d actual %0d", last_out + 1, cyc);
				errors++;
			end
			last_out = cyc;
		end
	endtask

	always @(negedge clk_i) begin
		if (!reset_i && out_valid_o && out_ready_i) begin
			check_output();
		end
	end

	initial begin
		reset_i = 1'b1;
		in_valid_i = 1'b0;
		insn_i = '0;
		out_ready_i = 1'b0;
		fill_table();
		repeat (10) @(posedge clk_i);
		reset_i <= 1'b0;
		@(negedge clk_i);
		phase = 1;
		drive_table();
		wait_outputs(n_rows);
		@(negedge clk_i);
		phase = 2;
		drive_table();
		wait_outputs(2 * n_rows);
		repeat (5) @(posedge clk_i);
		if (out_count != 2 * n_rows) begin
			$display("[ERROR] output count: expected %0d actual %0d", 2 * n_rows, out_count);
			errors++;
		end
		$display("checks done, errors: %0d", errors);
		if (errors == 0 && !hung) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+include
verilog/rvc_isa_pkg.sv
verilog/rvc_kind_pkg.sv
verilog/rvc_classify.sv
verilog/rvc_operand_gen.sv
verilog/rvc_encode.sv
verilog/rvc_expander.sv
test/rvc_expander_chk.sv
test/rvc_expander_tb.sv

// File: Makefile
OBJ = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module rvc_expander_tb -Mdir $(OBJ)

run: compile
	./$(OBJ)/Vrvc_expander_tb | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
